// ==== Makefile ====
# Verilator lint and simulation of the board control block

VERILATOR  ?= verilator
TOP        := board_ctl_tb
FILELIST   := list.f
COMMON     := --timing --assert --timescale 1ns/1ps
LINT_FLAGS := --lint-only $(COMMON)
SIM_FLAGS  := --binary -j 0 $(COMMON)
RUN_ARGS   := +verilator+error+limit+1000
BUILD_DIR  := obj_dir
PASS_TEXT  := TEST OK

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP) $(RUN_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

// ==== dv/board_ctl_sva.sv ====
/*
 * board control assertions
 * reset idle state, local bus handshake and interrupt line, bound to the top
 */
`timescale 1ns/1ps
`default_nettype none

module board_ctl_sva (
	input wire logic                    clk,
	input wire logic                    rst_n,
	input wire logic                    cs_n,
	input wire logic                    rd_n,
	input wire logic                    wr_n,
	input wire board_ctl_pkg::data_t    rdata,
	input wire logic                    rdy_n,
	input wire logic                    int_n,
	input wire board_ctl_pkg::sfp_vec_t txdis,
	input wire board_ctl_pkg::irq_vec_t int_source
);
	import board_ctl_pkg::*;

	logic acc;	// exactly one strobe with cs_n low
	bit   rst_seen;	// reset sampled at least once
	logic seen_acc;	// first access done
	int   fail_cnt;	// failures so far, polled at end of run

	assign acc = !cs_n && (rd_n != wr_n);

	always @(posedge clk)
	begin
		if (!rst_n)
			rst_seen <= 1'b1;
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			seen_acc <= 1'b0;
		else if (acc)
			seen_acc <= 1'b1;
	end

	// ----------------------------------------
	// reset and idle
	reset_idle: assert property (@(posedge clk)
		(rst_seen && !seen_acc) |-> (rdy_n && int_n && txdis == '0))
	else
	begin
		$error("rdy_n, int_n or txdis not idle before the first access");
		fail_cnt++;
	end

	// ----------------------------------------
	// local bus handshake
	rdy_after_acc: assert property (@(posedge clk) disable iff (!rst_n)
		!rdy_n |-> $past(acc))
	else
	begin
		$error("rdy_n low without an access in the cycle before");
		fail_cnt++;
	end

	rdy_release: assert property (@(posedge clk) disable iff (!rst_n)
		(!rdy_n && !acc) |=> rdy_n)
	else
	begin
		$error("rdy_n still low after the strobes were released");
		fail_cnt++;
	end

	rdata_hold: assert property (@(posedge clk) disable iff (!rst_n)
		(!rdy_n && $past(!rdy_n)) |-> $stable(rdata))
	else
	begin
		$error("rdata changed while rdy_n was low");
		fail_cnt++;
	end

	// ----------------------------------------
	// irq line follows the source one cycle later
	int_low: assert property (@(posedge clk) disable iff (!rst_n)
		(|int_source) |=> !int_n)
	else
	begin
		$error("int_n high with a source bit set");
		fail_cnt++;
	end

	int_high: assert property (@(posedge clk) disable iff (!rst_n)
		(int_source == '0) |=> int_n)
	else
	begin
		$error("int_n low with no source bit set");
		fail_cnt++;
	end

endmodule

bind board_ctl_top board_ctl_sva board_ctl_sva_inst (
	.clk        (clk),
	.rst_n      (rst_n),
	.cs_n       (cs_n),
	.rd_n       (rd_n),
	.wr_n       (wr_n),
	.rdata      (rdata),
	.rdy_n      (rdy_n),
	.int_n      (int_n),
	.txdis      (txdis),
	.int_source (int_source)
);

`default_nettype wire

// ==== dv/board_ctl_tb.sv ====
/*
 * board control testbench
 * local bus accesses, sfp pin stimulus and interrupt checks on board_ctl_top
 */
`timescale 1ns/1ps
`default_nettype none

module board_ctl_tb;
	import board_ctl_pkg::*;

	localparam int    CLK_PERIOD = 40;
	localparam int    RST_CYCLES = 16;
	localparam int    TICK       = 16;	// debounce tick in clocks
	localparam int    ACC        = 8;	// max cycles to ready
	localparam data_t LOGIC_VER  = 8'h3C;
	localparam data_t PCB_VER    = 8'h07;
	// reset, registers, handshake, debounce, events, sensor
	localparam int    RUN_CYCLES = (RST_CYCLES + 4 * ACC) + 12 * (2 * ACC) + 4 * (2 * ACC)
		+ 2 * (13 * TICK + 8 * ACC) + (8 * TICK + 16 * ACC) + (2 * TICK + 12 * ACC);
	localparam int    WDOG_CYCLES = 4 * RUN_CYCLES;

	logic     clk = 1'b0;
	logic     rst_n;
	logic     cs_n;
	logic     rd_n;
	logic     wr_n;
	addr_t    addr;
	data_t    wdata;
	logic     board_online;
	logic     lm80_n;
	logic     adt75_n;
	sfp_vec_t sfp_abs;
	sfp_vec_t sfp_los;
	data_t    rdata;
	logic     rdy_n;
	logic     int_n;
	sfp_vec_t txdis;

	int tests_run;
	int tests_failed;
	int checks;
	int errors;
	int test_err;	// errors in the running test

	always #(CLK_PERIOD / 2) clk = ~clk;

	board_ctl_top #(
		.LOGIC_VERSION (LOGIC_VER),
		.PCB_VERSION   (PCB_VER),
		.TICK_DIV      (TICK)
	) board_ctl_top_inst (
		.clk          (clk),
		.rst_n        (rst_n),
		.cs_n         (cs_n),
		.rd_n         (rd_n),
		.wr_n         (wr_n),
		.addr         (addr),
		.wdata        (wdata),
		.board_online (board_online),
		.lm80_n       (lm80_n),
		.adt75_n      (adt75_n),
		.sfp_abs      (sfp_abs),
		.sfp_los      (sfp_los),
		.rdata        (rdata),
		.rdy_n        (rdy_n),
		.int_n        (int_n),
		.txdis        (txdis)
	);

	// ----------------------------------------
	// checks and reporting
	task automatic check_value(input string name, input data_t got, input data_t exp);
		checks++;
		assert (got == exp)
		else
		begin
			$display("** Error: %s = 0x%02h, expected 0x%02h", name, got, exp);
			test_err++;
		end
	endtask

	task automatic check_true(input bit ok, input string what);
		checks++;
		assert (ok)
		else
		begin
			$display("%s", what);
			test_err++;
		end
	endtask

	task automatic finish_test(input string name);
		tests_run++;
		if (test_err == 0)
			$display("test %s passed", name);
		else
		begin
			$display("test %s failed with %0d errors", name, test_err);
			tests_failed++;
			errors += test_err;
		end
		test_err = 0;
	endtask

	// ----------------------------------------
	// local bus access held until ready then released
	task automatic bus_access(input logic is_wr, input addr_t a, input data_t d,
		input int hold, output data_t q);
		int n;
		@(posedge clk);
		addr  <= a;
		wdata <= d;
		cs_n  <= 1'b0;
		rd_n  <= is_wr;
		wr_n  <= !is_wr;
		n = 0;
		do
		begin
			@(posedge clk);
			n++;
		end
		while (rdy_n && n < ACC);
		q = rdata;	// value before this edge
		check_true(!rdy_n, $sformatf("no ready from the DUT at address 0x%03h", a));
		repeat (hold) @(posedge clk);	// back-pressure
		cs_n <= 1'b1;
		rd_n <= 1'b1;
		wr_n <= 1'b1;
	endtask

	task automatic write_reg(input addr_t a, input data_t d, input int hold);
		data_t unused;
		bus_access(1'b1, a, d, hold, unused);
	endtask

	task automatic read_expect(input addr_t a, input data_t exp, input string name,
		input int hold);
		data_t q;
		bus_access(1'b0, a, '0, hold, q);
		check_value(name, q, exp);
	endtask

	// ----------------------------------------
	// pins and interrupt line
	task automatic hold_pin(input bit is_los, input int port, input logic lvl,
		input int cycles);
		@(posedge clk);
		if (is_los)
			sfp_los[port] <= lvl;
		else
			sfp_abs[port] <= lvl;
		repeat (cycles) @(posedge clk);
	endtask

	task automatic wait_int(input logic lvl, input int max_cycles);
		int n;
		n = 0;
		while (int_n !== lvl && n < max_cycles)
		begin
			@(posedge clk);
			n++;
		end
		check_true(int_n === lvl, $sformatf("int_n did not go %s within %0d cycles",
			lvl ? "high" : "low", max_cycles));
	endtask

	// two short glitches and a held change, filtered state read after each
	task automatic debounce_check(input bit is_los, input int port);
		addr_t a;
		addr_t evt_a;
		string name;
		string evt_name;
		a        = is_los ? REG_SFP_LOS : REG_SFP_ABS;
		evt_a    = is_los ? REG_LOS_EVT : REG_ABS_EVT;
		name     = is_los ? "sfp_los state" : "sfp_abs state";
		evt_name = is_los ? "los_evt" : "abs_evt";
		hold_pin(is_los, port, 1'b0, TICK - 2);	// one clock short of a tick
		hold_pin(is_los, port, 1'b1, TICK + 1);	// sample back to high
		hold_pin(is_los, port, 1'b0, TICK - 2);	// one clock later in the tick phase
		hold_pin(is_los, port, 1'b1, 3 * TICK);
		read_expect(a, 8'hFF, name, 0);
		read_expect(evt_a, 8'h00, evt_name, 0);	// no state change from either glitch
		hold_pin(is_los, port, 1'b0, 3 * TICK);
		read_expect(a, ~(data_t'(1) << port), name, 0);
		hold_pin(is_los, port, 1'b1, 3 * TICK);
		read_expect(a, 8'hFF, name, 0);
	endtask

	// ----------------------------------------
	// test sequence
	initial
	begin
		data_t v;
		int    p_abs;
		int    p_los;
		bit    low_seen;
		void'($urandom(58));
		rst_n        <= 1'b0;
		cs_n         <= 1'b1;
		rd_n         <= 1'b1;
		wr_n         <= 1'b1;
		addr         <= '0;
		wdata        <= '0;
		board_online <= 1'b1;
		lm80_n       <= 1'b1;
		adt75_n      <= 1'b1;
		sfp_abs      <= '1;	// all cages empty
		sfp_los      <= '1;
		repeat (RST_CYCLES) @(posedge clk);
		rst_n <= 1'b1;

		repeat (2) @(posedge clk);
		check_value("txdis", txdis, '0);
		read_expect(REG_INT_MASK, 8'h0F, "int_mask", 0);
		finish_test("reset");

		v = data_t'($urandom);
		write_reg(REG_SCRATCH, v, 0);
		read_expect(REG_SCRATCH, ~v, "scratch", 0);
		v = data_t'($urandom);
		write_reg(REG_TXDIS, v, 0);
		read_expect(REG_TXDIS, v, "txdis reg", 0);
		check_value("txdis", txdis, v);
		read_expect(REG_VERSION, LOGIC_VER, "version", 0);
		read_expect(REG_PCB_VER, PCB_VER, "pcb_ver", 0);
		read_expect(REG_ONLINE, 8'h01, "online", 0);
		@(posedge clk);
		board_online <= 1'b0;
		read_expect(REG_ONLINE, 8'h00, "online", 0);
		read_expect(10'h3FF, 8'h00, "unmapped", 0);
		finish_test("registers");

		v = data_t'($urandom);
		write_reg(REG_SCRATCH, v, 3);	// long write
		read_expect(REG_SCRATCH, ~v, "scratch", 4);	// long read
		finish_test("handshake");

		write_reg(REG_INT_MASK, 8'h00, 0);	// keep irq quiet here
		p_abs = int'($urandom_range(N_SFP - 1, 0));
		p_los = int'($urandom_range(N_SFP - 1, 0));
		debounce_check(1'b0, p_abs);
		debounce_check(1'b1, p_los);
		read_expect(REG_ABS_EVT, data_t'(1) << p_abs, "abs_evt", 0);
		read_expect(REG_LOS_EVT, data_t'(1) << p_los, "los_evt", 0);
		read_expect(REG_INT_SRC, 8'h00, "int_source", 0);
		check_value("int_n", data_t'(int_n), 8'h01);
		finish_test("debounce");

		write_reg(REG_INT_MASK, 8'h0B, 0);	// abs cause off
		p_los = int'($urandom_range(N_SFP - 1, 0));
		hold_pin(1'b1, p_los, 1'b0, 3 * TICK);
		wait_int(1'b0, 2 * TICK);
		read_expect(REG_LOS_EVT, data_t'(1) << p_los, "los_evt", 3);	// clears once
		read_expect(REG_INT_SRC, 8'h08, "int_source", 0);
		wait_int(1'b1, 8);
		read_expect(REG_LOS_EVT, 8'h00, "los_evt", 0);
		read_expect(REG_INT_SRC, 8'h00, "int_source", 0);
		p_abs = int'($urandom_range(N_SFP - 1, 0));
		low_seen = 1'b0;
		@(posedge clk);
		sfp_abs[p_abs] <= 1'b0;
		repeat (3 * TICK)
		begin
			@(posedge clk);
			if (!int_n)
				low_seen = 1'b1;
		end
		check_true(!low_seen, "int_n went low on an ABS change with its mask bit cleared");
		read_expect(REG_ABS_EVT, data_t'(1) << p_abs, "abs_evt", 0);
		read_expect(REG_INT_SRC, 8'h00, "int_source", 0);
		finish_test("events");

		@(posedge clk);
		lm80_n <= 1'b0;
		wait_int(1'b0, 8);
		@(posedge clk);
		lm80_n <= 1'b1;
		repeat (4) @(posedge clk);	// sync flushed while the source stays set
		check_value("int_n", data_t'(int_n), 8'h00);
		read_expect(REG_INT_SRC, 8'h01, "int_source", 0);
		wait_int(1'b1, 8);
		read_expect(REG_INT_SRC, 8'h00, "int_source", 0);
		finish_test("sensor");

		$display("tests %0d, failed %0d, checks %0d, errors %0d, assertion failures %0d",
			tests_run, tests_failed, checks, errors,
			board_ctl_top_inst.board_ctl_sva_inst.fail_cnt);
		if (tests_failed == 0 && board_ctl_top_inst.board_ctl_sva_inst.fail_cnt == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

	// ----------------------------------------
	// watchdog
	initial
	begin
		repeat (WDOG_CYCLES) @(posedge clk);
		$display("watchdog expired after %0d cycles, test sequence did not finish",
			WDOG_CYCLES);
		$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== list.f ====
logic/board_ctl_pkg.sv
logic/sfp_status_if.sv
logic/lbus_regs.sv
logic/sfp_debounce.sv
logic/sfp_event_latch.sv
logic/irq_ctrl.sv
logic/board_ctl_top.sv
dv/board_ctl_sva.sv
dv/board_ctl_tb.sv

// ==== logic/board_ctl_pkg.sv ====
/*
 * board control package
 * widths, register map, interrupt cause positions and reset values
 * shared by the line-card register and interrupt block
 */
`default_nettype none

package board_ctl_pkg;

	// ----------------------------------------
	// widths
	localparam int ADDR_W = 10;	// local bus address
	localparam int DATA_W = 8;	// register width
	localparam int N_SFP  = 8;	// sfp cages on the card
	localparam int N_IRQ  = 4;	// interrupt causes

	typedef logic [ADDR_W-1:0] addr_t;
	typedef logic [DATA_W-1:0] data_t;
	typedef logic [N_SFP-1:0]  sfp_vec_t;	// one bit per port
	typedef logic [N_IRQ-1:0]  irq_vec_t;	// one bit per cause

	// ----------------------------------------
	// register map
	typedef enum addr_t {
		REG_SCRATCH  = 10'h000,	// reads back inverted
		REG_VERSION  = 10'h002,
		REG_PCB_VER  = 10'h005,
		REG_ONLINE   = 10'h00A,
		REG_INT_SRC  = 10'h027,	// read clear
		REG_INT_MASK = 10'h028,
		REG_TXDIS    = 10'h040,
		REG_SFP_ABS  = 10'h050,
		REG_SFP_LOS  = 10'h051,
		REG_ABS_EVT  = 10'h052,	// read clear
		REG_LOS_EVT  = 10'h053	// read clear
	} reg_addr_e;

	// interrupt cause bit positions
	localparam int IRQ_LM80  = 0;
	localparam int IRQ_ADT75 = 1;
	localparam int IRQ_ABS   = 2;
	localparam int IRQ_LOS   = 3;

	// ----------------------------------------
	// reset values and defaults
	localparam irq_vec_t INT_MASK_RST      = 4'hF;	// all causes enabled
	localparam sfp_vec_t SFP_STATE_RST     = '1;	// absent, no light
	localparam data_t    LOGIC_VERSION_DEF = 8'h01;
	localparam data_t    PCB_VERSION_DEF   = 8'h01;
	localparam int       TICK_DIV_DEF      = 1 << 20;	// clocks per debounce tick

endpackage

`default_nettype wire

// ==== logic/board_ctl_top.sv ====
/*
 * line-card board control top
 * local bus registers, sfp debounce and events, interrupt output
 */
`timescale 1ns/1ps
`default_nettype none

module board_ctl_top #(
	parameter board_ctl_pkg::data_t LOGIC_VERSION = board_ctl_pkg::LOGIC_VERSION_DEF,
	parameter board_ctl_pkg::data_t PCB_VERSION   = board_ctl_pkg::PCB_VERSION_DEF,
	parameter int                   TICK_DIV      = board_ctl_pkg::TICK_DIV_DEF
) (
	input  wire logic                    clk,
	input  wire logic                    rst_n,
	input  wire logic                    cs_n,
	input  wire logic                    rd_n,
	input  wire logic                    wr_n,
	input  wire board_ctl_pkg::addr_t    addr,
	input  wire board_ctl_pkg::data_t    wdata,
	input  wire logic                    board_online,
	input  wire logic                    lm80_n,
	input  wire logic                    adt75_n,
	input  wire board_ctl_pkg::sfp_vec_t sfp_abs,
	input  wire board_ctl_pkg::sfp_vec_t sfp_los,
	output board_ctl_pkg::data_t         rdata,
	output logic                         rdy_n,
	output logic                         int_n,
	output board_ctl_pkg::sfp_vec_t      txdis
);
	import board_ctl_pkg::*;

	irq_vec_t int_mask;
	irq_vec_t int_source;
	logic     clr_int;	// INT_SRC read-clear
	logic     abs_pending;
	logic     los_pending;

	sfp_status_if sfp_if ();	// debounce -> latch -> regs

	lbus_regs #(
		.LOGIC_VERSION (LOGIC_VERSION),
		.PCB_VERSION   (PCB_VERSION)
	) lbus_regs_inst (
		.clk          (clk),
		.rst_n        (rst_n),
		.cs_n         (cs_n),
		.rd_n         (rd_n),
		.wr_n         (wr_n),
		.addr         (addr),
		.wdata        (wdata),
		.board_online (board_online),
		.int_source   (int_source),
		.rdata        (rdata),
		.rdy_n        (rdy_n),
		.txdis        (txdis),
		.int_mask     (int_mask),
		.clr_int      (clr_int),
		.sfp          (sfp_if.regs_mp)
	);

	sfp_debounce #(
		.TICK_DIV (TICK_DIV)
	) sfp_debounce_inst (
		.clk     (clk),
		.rst_n   (rst_n),
		.sfp_abs (sfp_abs),
		.sfp_los (sfp_los),
		.sfp     (sfp_if.filt_mp)
	);

	sfp_event_latch sfp_event_latch_inst (
		.clk         (clk),
		.rst_n       (rst_n),
		.abs_pending (abs_pending),
		.los_pending (los_pending),
		.sfp         (sfp_if.latch_mp)
	);

	irq_ctrl irq_ctrl_inst (
		.clk         (clk),
		.rst_n       (rst_n),
		.lm80_n      (lm80_n),
		.adt75_n     (adt75_n),
		.abs_pending (abs_pending),
		.los_pending (los_pending),
		.int_mask    (int_mask),
		.clr_int     (clr_int),
		.int_source  (int_source),
		.int_n       (int_n)
	);

endmodule

`default_nettype wire

// ==== logic/irq_ctrl.sv ====
/*
 * interrupt controller
 * sensor pin sync, masked sticky source register, active-low irq line
 */
`timescale 1ns/1ps
`default_nettype none

module irq_ctrl (
	input  wire logic                    clk,
	input  wire logic                    rst_n,
	input  wire logic                    lm80_n,
	input  wire logic                    adt75_n,
	input  wire logic                    abs_pending,
	input  wire logic                    los_pending,
	input  wire board_ctl_pkg::irq_vec_t int_mask,
	input  wire logic                    clr_int,
	output board_ctl_pkg::irq_vec_t      int_source,
	output logic                         int_n
);
	import board_ctl_pkg::*;

	logic [1:0] sync1;	// {adt75_n, lm80_n}
	logic [1:0] sync2;
	irq_vec_t   cause;

	// ----------------------------------------
	// two-flop sync, idle high
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			sync1 <= 2'b11;
			sync2 <= 2'b11;
		end
		else
		begin
			sync1 <= {adt75_n, lm80_n};
			sync2 <= sync1;
		end
	end

	always_comb
	begin
		cause            = '0;
		cause[IRQ_LM80]  = ~sync2[0];	// sensor pins are active low
		cause[IRQ_ADT75] = ~sync2[1];
		cause[IRQ_ABS]   = abs_pending;
		cause[IRQ_LOS]   = los_pending;
	end

	// ----------------------------------------
	// sticky sources, a cause still active at clear sets again
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			int_source <= '0;
			int_n      <= 1'b1;
		end
		else
		begin
			int_source <= (clr_int ? '0 : int_source) | (cause & int_mask);
			int_n      <= ~|int_source;	// one cycle behind the source
		end
	end

endmodule

`default_nettype wire

// ==== logic/lbus_regs.sv ====
/*
 * local bus register file
 * access decode, control registers, read mux, ready and read-clear pulses
 */
`timescale 1ns/1ps
`default_nettype none

module lbus_regs #(
	parameter board_ctl_pkg::data_t LOGIC_VERSION = board_ctl_pkg::LOGIC_VERSION_DEF,
	parameter board_ctl_pkg::data_t PCB_VERSION   = board_ctl_pkg::PCB_VERSION_DEF
) (
	input  wire logic                     clk,
	input  wire logic                     rst_n,
	input  wire logic                     cs_n,
	input  wire logic                     rd_n,
	input  wire logic                     wr_n,
	input  wire board_ctl_pkg::addr_t     addr,
	input  wire board_ctl_pkg::data_t     wdata,
	input  wire logic                     board_online,
	input  wire board_ctl_pkg::irq_vec_t  int_source,
	output board_ctl_pkg::data_t          rdata,
	output logic                          rdy_n,
	output board_ctl_pkg::sfp_vec_t       txdis,
	output board_ctl_pkg::irq_vec_t       int_mask,
	output logic                          clr_int,
	sfp_status_if.regs_mp                 sfp
);
	import board_ctl_pkg::*;

	logic  rd_act;	// read strobe only
	logic  wr_act;	// write strobe only
	logic  acc;
	logic  rd_first;	// first cycle of a read
	logic  wr_first;
	logic  [2:0] rc_pend;	// {los_evt, abs_evt, int_src} read in progress
	data_t scratch;
	data_t rd_mux;

	// ----------------------------------------
	// access decode
	assign rd_act   = ~cs_n & ~rd_n & wr_n;
	assign wr_act   = ~cs_n & ~wr_n & rd_n;
	assign acc      = rd_act | wr_act;
	assign rd_first = rd_act & rdy_n;	// rdy_n still high on the first cycle
	assign wr_first = wr_act & rdy_n;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			rdy_n <= 1'b1;
		else
			rdy_n <= ~acc;	// low for as long as the strobe is held
	end

	// ----------------------------------------
	// control registers
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			scratch  <= '0;
			int_mask <= INT_MASK_RST;
			txdis    <= '0;
		end
		else if (wr_first)
		begin
			case (addr)
				REG_SCRATCH:  scratch  <= ~wdata;	// host sees its value inverted
				REG_INT_MASK: int_mask <= wdata[N_IRQ-1:0];
				REG_TXDIS:    txdis    <= wdata[N_SFP-1:0];
				default:      ;	// read-only or unmapped
			endcase
		end
	end

	// ----------------------------------------
	// read path
	always_comb
	begin
		case (addr)
			REG_SCRATCH:  rd_mux = scratch;
			REG_VERSION:  rd_mux = LOGIC_VERSION;
			REG_PCB_VER:  rd_mux = PCB_VERSION;
			REG_ONLINE:   rd_mux = data_t'(board_online);	// bit 0 only
			REG_INT_SRC:  rd_mux = data_t'(int_source);
			REG_INT_MASK: rd_mux = data_t'(int_mask);
			REG_TXDIS:    rd_mux = data_t'(txdis);
			REG_SFP_ABS:  rd_mux = data_t'(sfp.abs_state);
			REG_SFP_LOS:  rd_mux = data_t'(sfp.los_state);
			REG_ABS_EVT:  rd_mux = data_t'(sfp.abs_evt);
			REG_LOS_EVT:  rd_mux = data_t'(sfp.los_evt);
			default:      rd_mux = '0;	// unmapped reads zero
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (rd_first)
			rdata <= rd_mux;	// held for the rest of the access
	end

	// ----------------------------------------
	// read-clear, one pulse after the strobe is released
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			rc_pend     <= '0;
			clr_int     <= 1'b0;
			sfp.clr_abs <= 1'b0;
			sfp.clr_los <= 1'b0;
		end
		else
		begin
			clr_int     <= 1'b0;
			sfp.clr_abs <= 1'b0;
			sfp.clr_los <= 1'b0;
			if (rd_first)
			begin
				rc_pend <= {addr == REG_LOS_EVT, addr == REG_ABS_EVT, addr == REG_INT_SRC};
			end
			else if (!acc)
			begin
				rc_pend     <= '0;	// fires once however long the read was
				clr_int     <= rc_pend[0];
				sfp.clr_abs <= rc_pend[1];
				sfp.clr_los <= rc_pend[2];
			end
		end
	end

endmodule

`default_nettype wire

// ==== logic/sfp_debounce.sv ====
/*
 * sfp pin debounce
 * tick generator and two-sample filter on the abs and los pins
 */
`timescale 1ns/1ps
`default_nettype none

module sfp_debounce #(
	parameter int TICK_DIV = board_ctl_pkg::TICK_DIV_DEF
) (
	input  wire logic                    clk,
	input  wire logic                    rst_n,
	input  wire board_ctl_pkg::sfp_vec_t sfp_abs,
	input  wire board_ctl_pkg::sfp_vec_t sfp_los,
	sfp_status_if.filt_mp                sfp
);
	import board_ctl_pkg::*;

	localparam int CNT_W = (TICK_DIV > 1) ? $clog2(TICK_DIV) : 1;
	localparam int W     = 2 * N_SFP;	// los in the upper half

	logic [CNT_W-1:0] cnt;
	logic             tick;
	logic [W-1:0]     pin_all;
	logic [W-1:0]     smp;	// last differing pin value
	logic [W-1:0]     state;

	// ----------------------------------------
	// tick every TICK_DIV clocks
	assign tick = (cnt == CNT_W'(TICK_DIV - 1));

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			cnt <= '0;
		else
			cnt <= tick ? '0 : cnt + 1'b1;
	end

	// ----------------------------------------
	// per-pin filter, state only follows a sample seen twice
	assign pin_all = {sfp_los, sfp_abs};

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			smp   <= {SFP_STATE_RST, SFP_STATE_RST};
			state <= {SFP_STATE_RST, SFP_STATE_RST};
		end
		else if (tick)
		begin
			for (int i = 0; i < W; i++)
			begin
				if (pin_all[i] == smp[i])
					state[i] <= smp[i];	// stable across a tick
				else
					smp[i] <= pin_all[i];	// new value, wait one more tick
			end
		end
	end

	assign sfp.abs_state = state[N_SFP-1:0];
	assign sfp.los_state = state[W-1:N_SFP];

endmodule

`default_nettype wire

// ==== logic/sfp_event_latch.sv ====
/*
 * sfp event latch
 * flags any change of filtered abs/los state per port until read-clear
 */
`timescale 1ns/1ps
`default_nettype none

module sfp_event_latch (
	input  wire logic      clk,
	input  wire logic      rst_n,
	output logic           abs_pending,
	output logic           los_pending,
	sfp_status_if.latch_mp sfp
);
	import board_ctl_pkg::*;

	localparam int W = 2 * N_SFP;	// los in the upper half

	logic [W-1:0] cur;
	logic [W-1:0] prev;	// state one cycle ago
	logic [W-1:0] chg;
	logic [W-1:0] clr;
	logic [W-1:0] evt;

	assign cur = {sfp.los_state, sfp.abs_state};
	assign chg = cur ^ prev;	// either direction counts
	assign clr = {{N_SFP{sfp.clr_los}}, {N_SFP{sfp.clr_abs}}};

	// ----------------------------------------
	// a change in the clear cycle wins
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			prev <= {SFP_STATE_RST, SFP_STATE_RST};
			evt  <= '0;
		end
		else
		begin
			prev <= cur;
			evt  <= (evt & ~clr) | chg;
		end
	end

	assign sfp.abs_evt = evt[N_SFP-1:0];
	assign sfp.los_evt = evt[W-1:N_SFP];
	assign abs_pending = |evt[N_SFP-1:0];	// feeds the abs cause
	assign los_pending = |evt[W-1:N_SFP];

endmodule

`default_nettype wire

// ==== logic/sfp_status_if.sv ====
/*
 * sfp status interface
 * filtered abs/los state, per-port event flags and read-clear strobes
 */
`timescale 1ns/1ps
`default_nettype none

interface sfp_status_if;
	import board_ctl_pkg::*;

	sfp_vec_t abs_state;	// filtered presence, 1 = absent
	sfp_vec_t los_state;	// filtered loss of signal
	sfp_vec_t abs_evt;	// sticky change flags
	sfp_vec_t los_evt;
	logic     clr_abs;	// one-cycle clear pulses
	logic     clr_los;

	modport filt_mp (output abs_state, los_state);
	modport latch_mp (input abs_state, los_state, clr_abs, clr_los,
		output abs_evt, los_evt);
	modport regs_mp (input abs_state, los_state, abs_evt, los_evt,
		output clr_abs, clr_los);

endinterface

`default_nettype wire
